//--- multicore_bus.f
logic/bus_pkg.sv
logic/hart_port_pkg.sv
logic/front_side_bus_if.sv
logic/generic_bus_if.sv
logic/memory_controller.sv
logic/generic_nonpipeline.sv
logic/multicore_bus.sv
tests/multicore_bus_asserts.sv
tests/multicore_bus_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile with Verilator, run, and pass only if the pass line shows up in the output
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module multicore_bus_tb \
    -f multicore_bus.f -o multicore_bus_sim &&
./obj_dir/multicore_bus_sim | tee /dev/stderr | grep -q "All tests passed" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- tests/multicore_bus_tb.sv
`default_nettype none

module multicore_bus_tb
    import bus_pkg::*;
    import hart_port_pkg::*;
();

    localparam int NUM_HARTS = 2;
    localparam int PORTS     = NUM_HARTS * 2;
    localparam int NUM_ROWS  = 13;
    localparam int TIMEOUT   = 200;

    // one front-side access and what it must return
    typedef struct {
        int                port;
        logic              wen;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        byte_en_t          byte_en;
        logic [DATA_W-1:0] exp_rdata;
        logic              exp_error;
    } row_t;

    logic              CLK;
    logic              rst_n;
    logic [PORTS-1:0]  req;
    logic [PORTS-1:0]  wen;
    logic [ADDR_W-1:0] addr    [PORTS-1:0];
    logic [DATA_W-1:0] wdata   [PORTS-1:0];
    byte_en_t          byte_en [PORTS-1:0];
    logic [DATA_W-1:0] rdata   [PORTS-1:0];
    logic [PORTS-1:0]  done;
    logic [PORTS-1:0]  error;
    logic              bus_ren;
    logic              bus_wen;
    logic [ADDR_W-1:0] bus_addr;
    logic [DATA_W-1:0] bus_wdata;
    byte_en_t          bus_byte_en;
    logic [DATA_W-1:0] bus_rdata;
    logic              bus_busy;
    logic              bus_error;

    // external memory model state
    logic [DATA_W-1:0] mem [256];
    logic              in_flight;
    int                wait_left;
    integer            seed;
    logic [ADDR_W-1:0] ext_addrs [$];

    row_t              rows [NUM_ROWS];
    logic [ADDR_W-1:0] group_addr [PORTS];
    logic [DATA_W-1:0] group_data [PORTS];

    int data_errs   = 0;
    int status_errs = 0;
    int order_errs  = 0;
    int count_errs  = 0;
    int timeouts    = 0;

    multicore_bus #(.NUM_HARTS(NUM_HARTS)) multicore_bus_inst (.*);

    bind multicore_bus multicore_bus_asserts #(.NUM_HARTS(NUM_HARTS)) asserts_inst (.*);

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    // slave model with a busy stretch of 0..3 cycles per transaction
    always @(posedge CLK) begin
        #5;
        if (in_flight) begin
            // wait_left at zero means it completed at this edge
            if (wait_left == 0) begin
                in_flight = 1'b0;
            end else begin
                wait_left = wait_left - 1;
                bus_busy  = (wait_left != 0);
            end
        end else if (bus_ren || bus_wen) begin
            in_flight = 1'b1;
            wait_left = $random(seed) & 3;
            bus_busy  = (wait_left != 0);
            bus_error = (bus_addr >= 32'h0000_0F00);
            bus_rdata = bus_ren ? mem[bus_addr[9:2]] : '0;
            ext_addrs.push_back(bus_addr);
            // byte lanes merged into the stored word
            for (int b = 0; b < BYTES_W; b++) begin
                if (bus_wen && !bus_error && bus_byte_en[b]) begin
                    mem[bus_addr[9:2]][b*8 +: 8] = bus_wdata[b*8 +: 8];
                end
            end
        end
    end

    // status as seen on the top-level outputs
    function automatic l2_state_t seen_status(input logic d, input logic e, input logic active);
        l2_state_t s;
        s = d ? (e ? L2_ERROR : L2_ACCESS) : ((e || active) ? L2_BUSY : L2_IDLE);
        return s;
    endfunction

    task automatic check_data(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                              input string msg);
        if (got !== exp) begin
            data_errs++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_error(input l2_state_t got, input l2_state_t exp, input string msg);
        if (got !== exp) begin
            status_errs++;
            $display("MISMATCH at %0t: %s got %s expected %s", $time, msg, got.name(), exp.name());
        end
    endtask

    task automatic check_order(input int got, input int exp, input string msg);
        if (got != exp) begin
            order_errs++;
            $display("MISMATCH at %0t: %s got port %0d expected port %0d", $time, msg, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string msg);
        if (got != exp) begin
            count_errs++;
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, msg, got, exp);
        end
    endtask

    // one access on one port checked on its done cycle
    task automatic run_row(input row_t r);
        int        cycles;
        int        ext_before;
        req_kind_t kind;
        logic      refused;
        // odd index bit marks a data port
        kind    = r.port[0] ? PORT_DATA : PORT_IFETCH;
        refused = r.wen && (kind == PORT_IFETCH);
        @(posedge CLK);
        #5;
        ext_before      = ext_addrs.size();
        req[r.port]     = 1'b1;
        wen[r.port]     = r.wen;
        addr[r.port]    = r.addr;
        wdata[r.port]   = r.wdata;
        byte_en[r.port] = r.byte_en;
        cycles = 0;
        do begin
            @(posedge CLK);
            #5;
            cycles++;
        end while (!done[r.port] && cycles < TIMEOUT);
        if (!done[r.port]) begin
            timeouts++;
            $display("timeout: port %0d saw no done within %0d cycles", r.port, TIMEOUT);
        end else begin
            if (!r.wen && !r.exp_error) begin
                check_data(rdata[r.port], r.exp_rdata, "read data");
            end
            check_error(seen_status(1'b1, error[r.port], 1'b0),
                        r.exp_error ? L2_ERROR : L2_ACCESS, "completion status");
            check_count($countones(done), 1, "ports with done");
            check_count($countones(error), int'(r.exp_error), "ports with error");
            // refused fetch-port writes never reach the bus
            check_count(ext_addrs.size() - ext_before, refused ? 0 : 1, "external transactions");
        end
        req[r.port] = 1'b0;
    endtask

    // every port at once while the pointer sits at port 0
    task automatic run_group();
        logic [PORTS-1:0] finished;
        int               cycles;
        int               found;
        @(posedge CLK);
        #5;
        ext_addrs.delete();
        finished = '0;
        for (int p = 0; p < PORTS; p++) begin
            req[p]     = 1'b1;
            wen[p]     = 1'b0;
            addr[p]    = group_addr[p];
            byte_en[p] = '1;
        end
        cycles = 0;
        while (finished != '1 && cycles < TIMEOUT) begin
            @(posedge CLK);
            #5;
            cycles++;
            for (int p = 0; p < PORTS; p++) begin
                if (done[p]) begin
                    check_count(int'(finished[p]), 0, "repeated done on one port");
                    check_data(rdata[p], group_data[p], "group read data");
                    finished[p] = 1'b1;
                    req[p]      = 1'b0;
                end
            end
        end
        if (finished != '1) begin
            timeouts++;
            $display("timeout: group ports %b still without done after %0d cycles",
                     ~finished, TIMEOUT);
        end
        check_count(ext_addrs.size(), PORTS, "external transactions in group");
        foreach (ext_addrs[i]) begin
            found = -1;
            for (int p = 0; p < PORTS; p++) begin
                if (ext_addrs[i] == group_addr[p]) begin
                    found = p;
                end
            end
            check_order(found, i, "round-robin order");
        end
    endtask

    initial begin
        seed      = 32'h07fcfa0b;
        rst_n     = 1'b0;
        req       = '0;
        wen       = '0;
        bus_rdata = '0;
        bus_busy  = 1'b0;
        bus_error = 1'b0;
        in_flight = 1'b0;
        wait_left = 0;
        for (int p = 0; p < PORTS; p++) begin
            addr[p]    = '0;
            wdata[p]   = '0;
            byte_en[p] = '0;
        end
        // fill word depends on the whole word index
        for (int i = 0; i < 256; i++) begin
            mem[i] = {8'hA5, 8'(i), ~8'(i), 8'(i) ^ 8'h3C};
        end
        // port, wen, addr, wdata, byte_en, expected rdata, expected error
        rows[0]  = '{1, 1'b1, 32'h0000_0010, 32'hCAFE_F00D, 4'hF, 32'h0, 1'b0};
        rows[1]  = '{1, 1'b0, 32'h0000_0010, 32'h0, 4'hF, 32'hCAFE_F00D, 1'b0};
        rows[2]  = '{3, 1'b0, 32'h0000_0010, 32'h0, 4'hF, 32'hCAFE_F00D, 1'b0};
        rows[3]  = '{3, 1'b1, 32'h0000_0010, 32'h1122_3344, 4'b0101, 32'h0, 1'b0};
        rows[4]  = '{1, 1'b0, 32'h0000_0010, 32'h0, 4'hF, 32'hCA22_F044, 1'b0};
        rows[5]  = '{0, 1'b1, 32'h0000_0010, 32'hDEAD_BEEF, 4'hF, 32'h0, 1'b1};
        rows[6]  = '{2, 1'b0, 32'h0000_0010, 32'h0, 4'hF, 32'hCA22_F044, 1'b0};
        rows[7]  = '{1, 1'b0, 32'h0000_0F00, 32'h0, 4'hF, 32'h0, 1'b1};
        rows[8]  = '{2, 1'b1, 32'h0000_0020, 32'h5555_AAAA, 4'hF, 32'h0, 1'b1};
        rows[9]  = '{3, 1'b1, 32'h0000_0F04, 32'h1234_5678, 4'hF, 32'h0, 1'b1};
        rows[10] = '{1, 1'b1, 32'h0000_0020, 32'h0BAD_CAFE, 4'b1100, 32'h0, 1'b0};
        rows[11] = '{3, 1'b0, 32'h0000_0020, 32'h0, 4'hF, 32'h0BAD_F734, 1'b0};
        // ends on port 3 so the pointer wraps to 0
        rows[12] = '{3, 1'b0, 32'h0000_0030, 32'h0, 4'hF, 32'hA50C_F330, 1'b0};
        group_addr = '{32'h0000_0040, 32'h0000_0010, 32'h0000_0020, 32'h0000_0044};
        group_data = '{32'hA510_EF2C, 32'hCA22_F044, 32'h0BAD_F734, 32'hA511_EE2D};

        repeat (2) @(posedge CLK);
        #5;
        rst_n = 1'b1;
        // no activity before the first request
        repeat (3) begin
            @(posedge CLK);
            #5;
            check_error(seen_status(|done, |error, bus_ren || bus_wen), L2_IDLE,
                        "idle after reset");
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(rows[i]);
        end
        run_group();

        $display("errors: data %0d, status %0d, order %0d, count %0d, timeout %0d",
                 data_errs, status_errs, order_errs, count_errs, timeouts);
        if (data_errs + status_errs + order_errs + count_errs + timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/multicore_bus_asserts.sv
`default_nettype none

module multicore_bus_asserts
    import bus_pkg::*;
#(
    parameter int NUM_HARTS = 2
) (
    input logic                   CLK,
    input logic                   rst_n,
    input logic [NUM_HARTS*2-1:0] done,
    input logic                   bus_ren,
    input logic                   bus_wen,
    input logic [ADDR_W-1:0]      bus_addr,
    input logic [DATA_W-1:0]      bus_wdata,
    input byte_en_t               bus_byte_en,
    input logic                   bus_busy
);

    // responses go out one port at a time
    a_one_done: assert property (@(posedge CLK) disable iff (!rst_n) $onehot0(done))
        else $error("done raised on more than one port");

    // done is a single-cycle pulse
    a_done_pulse: assert property (@(posedge CLK) disable iff (!rst_n) |done |=> done == '0)
        else $error("done held for more than one cycle");

    // read and write strobes never together
    a_strobes: assert property (@(posedge CLK) disable iff (!rst_n) !(bus_ren && bus_wen))
        else $error("bus_ren and bus_wen high together");

    // stalled request holds every field
    a_hold: assert property (@(posedge CLK) disable iff (!rst_n)
        (bus_ren || bus_wen) && bus_busy |=> $stable(bus_ren) && $stable(bus_wen)
            && $stable(bus_addr) && $stable(bus_wdata) && $stable(bus_byte_en))
        else $error("external request changed while bus_busy was high");

endmodule

`default_nettype wire

//--- logic/multicore_bus.sv
`default_nettype none

module multicore_bus
    import bus_pkg::*;
#(
    parameter int NUM_HARTS = 2
) (
    input  logic                    CLK,
    input  logic                    rst_n,

    // front-side ports, fetch at 2h and data at 2h+1
    input  logic [NUM_HARTS*2-1:0]  req,
    input  logic [NUM_HARTS*2-1:0]  wen,
    input  logic [ADDR_W-1:0]       addr    [NUM_HARTS*2-1:0],
    input  logic [DATA_W-1:0]       wdata   [NUM_HARTS*2-1:0],
    input  byte_en_t                byte_en [NUM_HARTS*2-1:0],
    output logic [DATA_W-1:0]       rdata   [NUM_HARTS*2-1:0],
    output logic [NUM_HARTS*2-1:0]  done,
    output logic [NUM_HARTS*2-1:0]  error,

    // external memory bus, one transaction at a time
    output logic                    bus_ren,
    output logic                    bus_wen,
    output logic [ADDR_W-1:0]       bus_addr,
    output logic [DATA_W-1:0]       bus_wdata,
    output byte_en_t                bus_byte_en,
    input  logic [DATA_W-1:0]       bus_rdata,
    input  logic                    bus_busy,
    input  logic                    bus_error
);

    front_side_bus_if front_side [NUM_HARTS*2-1:0] ();
    generic_bus_if    pipeline_trans_if ();

    // plain port arrays onto the per-port interfaces
    for (genvar p = 0; p < NUM_HARTS * 2; p++) begin : g_fsb
        assign front_side[p].req     = req[p];
        assign front_side[p].wen     = wen[p];
        assign front_side[p].addr    = addr[p];
        assign front_side[p].wdata   = wdata[p];
        assign front_side[p].byte_en = byte_en[p];

        assign rdata[p] = front_side[p].rdata;
        assign done[p]  = front_side[p].done;
        assign error[p] = front_side[p].error;
    end

    // arbiter and response router
    memory_controller #(
        .NUM_HARTS(NUM_HARTS)
    ) mc (
        .CLK(CLK),
        .rst_n(rst_n),
        .front_side(front_side),
        .out_gen_bus_if(pipeline_trans_if)
    );

    // non-pipelined bridge to the external bus
    generic_nonpipeline bt (
        .CLK(CLK),
        .rst_n(rst_n),
        .pipeline_trans_if(pipeline_trans_if),
        .bus_ren(bus_ren),
        .bus_wen(bus_wen),
        .bus_addr(bus_addr),
        .bus_wdata(bus_wdata),
        .bus_byte_en(bus_byte_en),
        .bus_rdata(bus_rdata),
        .bus_busy(bus_busy),
        .bus_error(bus_error)
    );

endmodule

`default_nettype wire

//--- logic/generic_nonpipeline.sv
`default_nettype none

module generic_nonpipeline
    import bus_pkg::*;
(
    input  logic              CLK,
    input  logic              rst_n,
    generic_bus_if.bridge     pipeline_trans_if,
    output logic              bus_ren,
    output logic              bus_wen,
    output logic [ADDR_W-1:0] bus_addr,
    output logic [DATA_W-1:0] bus_wdata,
    output byte_en_t          bus_byte_en,
    input  logic [DATA_W-1:0] bus_rdata,
    input  logic              bus_busy,
    input  logic              bus_error
);

    // capture, drive externally, report back for one cycle
    typedef enum logic [1:0] {
        BR_IDLE = 2'd0,
        BR_EXT  = 2'd1,
        BR_RESP = 2'd2
    } br_state_t;

    br_state_t state;

    logic              ren_q;
    logic              wen_q;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] wdata_q;
    byte_en_t          be_q;
    logic [DATA_W-1:0] rdata_q;
    logic              err_q;

    logic capture;
    logic finish;

    // new request only taken when nothing is in flight
    assign capture = (state == BR_IDLE) && (pipeline_trans_if.ren || pipeline_trans_if.wen);
    // external side is done on its first not-busy cycle
    assign finish  = (state == BR_EXT) && !bus_busy;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state <= BR_IDLE;
            ren_q <= 1'b0;
            wen_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            case (state)
                BR_IDLE: begin
                    if (capture) begin
                        ren_q <= pipeline_trans_if.ren;
                        wen_q <= pipeline_trans_if.wen;
                        state <= BR_EXT;
                    end
                end
                BR_EXT: begin
                    // outputs stay put while the slave stalls
                    if (finish) begin
                        ren_q <= 1'b0;
                        wen_q <= 1'b0;
                        err_q <= bus_error;
                        state <= BR_RESP;
                    end
                end
                default: begin
                    state <= BR_IDLE;
                end
            endcase
        end
    end

    // address, data and enables follow the strobes
    always_ff @(posedge CLK) begin
        if (capture) begin
            addr_q  <= pipeline_trans_if.addr;
            wdata_q <= pipeline_trans_if.wdata;
            be_q    <= pipeline_trans_if.byte_en;
        end
        if (finish) begin
            rdata_q <= bus_rdata;
        end
    end

    assign bus_ren     = ren_q;
    assign bus_wen     = wen_q;
    assign bus_addr    = addr_q;
    assign bus_wdata   = wdata_q;
    assign bus_byte_en = be_q;

    // busy everywhere except the single response cycle
    assign pipeline_trans_if.busy  = (state != BR_RESP);
    assign pipeline_trans_if.rdata = rdata_q;
    assign pipeline_trans_if.error = err_q;

endmodule

`default_nettype wire

//--- logic/memory_controller.sv
`default_nettype none

module memory_controller
    import bus_pkg::*;
    import hart_port_pkg::*;
#(
    parameter int NUM_HARTS = 2
) (
    input logic                  CLK,
    input logic                  rst_n,
    front_side_bus_if.controller front_side [NUM_HARTS*2-1:0],
    generic_bus_if.cpu           out_gen_bus_if
);

    localparam int PORTS = NUM_HARTS * 2;
    localparam int IDX_W = $clog2(PORTS);

    // arbitrate, hold one grant, wait for the bridge, pulse done
    typedef enum logic [1:0] {
        ST_ARB   = 2'd0,
        ST_GRANT = 2'd1,
        ST_WAIT  = 2'd2,
        ST_DONE  = 2'd3
    } mc_state_t;

    mc_state_t state;

    // flattened copies of the port interfaces
    // an interface array only takes constant indices
    logic [PORTS-1:0]  req_vec;
    logic [PORTS-1:0]  wen_vec;
    logic [PORTS-1:0]  done_vec;
    logic [ADDR_W-1:0] addr_arr  [PORTS-1:0];
    logic [DATA_W-1:0] wdata_arr [PORTS-1:0];
    byte_en_t          be_arr    [PORTS-1:0];

    // round-robin search result
    logic [IDX_W-1:0] rr_ptr;
    logic [IDX_W-1:0] rr_next;
    logic [IDX_W-1:0] pick_idx;
    logic             pick_valid;

    // the port holding the grant
    logic [IDX_W-1:0] grant_idx;
    logic             sel_wen;
    logic             sel_ifetch;

    // backend progress and completion events
    l2_state_t         l2_state;
    logic              refuse;
    logic              complete;
    logic [DATA_W-1:0] resp_rdata;
    logic              resp_error;

    for (genvar g = 0; g < PORTS; g++) begin : g_port
        assign req_vec[g]   = front_side[g].req;
        assign wen_vec[g]   = front_side[g].wen;
        assign addr_arr[g]  = front_side[g].addr;
        assign wdata_arr[g] = front_side[g].wdata;
        assign be_arr[g]    = front_side[g].byte_en;

        // response goes only to the granted port
        assign done_vec[g]         = (state == ST_DONE) && (grant_idx == IDX_W'(g));
        assign front_side[g].done  = done_vec[g];
        assign front_side[g].rdata = done_vec[g] ? resp_rdata : '0;
        assign front_side[g].error = done_vec[g] && resp_error;
    end

    // first requester at or after rr_ptr, wrapping around
    always_comb begin
        int j;
        pick_valid = 1'b0;
        pick_idx   = '0;
        for (int i = 0; i < PORTS; i++) begin
            j = (int'(rr_ptr) + i) % PORTS;
            if (!pick_valid && req_vec[j]) begin
                pick_valid = 1'b1;
                pick_idx   = IDX_W'(j);
            end
        end
    end

    // search starts one past the port just granted
    assign rr_next = (pick_idx == IDX_W'(PORTS - 1)) ? '0 : pick_idx + 1'b1;

    assign sel_wen    = wen_vec[grant_idx];
    assign sel_ifetch = (port_kind(grant_idx) == PORT_IFETCH);

    // fetch ports are read-only, their writes never leave here
    assign refuse = (state == ST_GRANT) && sel_wen && sel_ifetch;

    // internal request is live for the whole wait state
    assign out_gen_bus_if.ren     = (state == ST_WAIT) && !sel_wen;
    assign out_gen_bus_if.wen     = (state == ST_WAIT) && sel_wen;
    assign out_gen_bus_if.addr    = addr_arr[grant_idx];
    assign out_gen_bus_if.wdata   = wdata_arr[grant_idx];
    assign out_gen_bus_if.byte_en = be_arr[grant_idx];

    // backend status as seen from this side
    always_comb begin
        if (state != ST_WAIT) begin
            l2_state = L2_IDLE;
        end else if (out_gen_bus_if.busy) begin
            l2_state = L2_BUSY;
        end else if (out_gen_bus_if.error) begin
            l2_state = L2_ERROR;
        end else begin
            l2_state = L2_ACCESS;
        end
    end

    // first not-busy cycle ends the transaction
    assign complete = (l2_state == L2_ACCESS) || (l2_state == L2_ERROR);

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_ARB;
            grant_idx  <= '0;
            rr_ptr     <= '0;
            resp_error <= 1'b0;
        end else begin
            case (state)
                ST_ARB: begin
                    if (pick_valid) begin
                        grant_idx <= pick_idx;
                        rr_ptr    <= rr_next;
                        state     <= ST_GRANT;
                    end
                end
                ST_GRANT: begin
                    // refused write skips the bridge entirely
                    if (refuse) begin
                        resp_error <= 1'b1;
                        state      <= ST_DONE;
                    end else begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (complete) begin
                        resp_error <= (l2_state == L2_ERROR);
                        state      <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    // one done cycle, requester drops req after it
                    state <= ST_ARB;
                end
                default: begin
                    state <= ST_ARB;
                end
            endcase
        end
    end

    // read data held for the done cycle
    always_ff @(posedge CLK) begin
        if (refuse) begin
            resp_rdata <= '0;
        end else if (complete) begin
            resp_rdata <= out_gen_bus_if.rdata;
        end
    end

endmodule

`default_nettype wire

//--- logic/generic_bus_if.sv
`default_nettype none

interface generic_bus_if
    import bus_pkg::*;
();

    // transaction request, held until busy is seen low
    logic              ren;
    logic              wen;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    byte_en_t          byte_en;

    // completion status
    logic              busy;
    logic [DATA_W-1:0] rdata;
    logic              error;

    // initiator end, the memory controller
    modport cpu (
        output ren, wen, addr, wdata, byte_en,
        input  busy, rdata, error
    );

    // target end, the bus bridge
    modport bridge (
        input  ren, wen, addr, wdata, byte_en,
        output busy, rdata, error
    );

endinterface

`default_nettype wire

//--- logic/front_side_bus_if.sv
`default_nettype none

interface front_side_bus_if
    import bus_pkg::*;
();

    // request side, held stable while req is high
    logic              req;
    logic              wen;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    byte_en_t          byte_en;

    // response side, valid only while done is high
    logic [DATA_W-1:0] rdata;
    logic              done;
    logic              error;

    // the hart side of the port
    modport requester (
        output req, wen, addr, wdata, byte_en,
        input  rdata, done, error
    );

    // the memory controller side
    // done is a single-cycle pulse per request
    modport controller (
        input  req, wen, addr, wdata, byte_en,
        output rdata, done, error
    );

endinterface

`default_nettype wire

//--- logic/hart_port_pkg.sv
`default_nettype none

package hart_port_pkg;

    // what sits behind a front-side port
    typedef enum logic {
        PORT_IFETCH = 1'b0,
        PORT_DATA   = 1'b1
    } req_kind_t;

    // hart h owns port 2h for fetch and 2h+1 for data
    // so the low index bit alone picks the kind
    function automatic req_kind_t port_kind(input int unsigned idx);
        req_kind_t kind;
        kind = (idx % 2 == 0) ? PORT_IFETCH : PORT_DATA;
        return kind;
    endfunction

endpackage

`default_nettype wire

//--- logic/bus_pkg.sv
`default_nettype none

package bus_pkg;

    // address and data width of every bus in the design
    parameter int ADDR_W = 32;
    parameter int DATA_W = 32;

    // bytes per data word
    parameter int BYTES_W = DATA_W / 8;

    // one enable bit per data byte, bit 0 is byte lane 0
    typedef logic [BYTES_W-1:0] byte_en_t;

    // backend status as the controller sees it
    // derived from the internal bus each cycle
    typedef enum logic [1:0] {
        // no request on the internal bus
        L2_IDLE   = 2'd0,
        // request out, bridge still working
        L2_BUSY   = 2'd1,
        // completed without error
        L2_ACCESS = 2'd2,
        // completed, slave flagged an error
        L2_ERROR  = 2'd3
    } l2_state_t;

endpackage

`default_nettype wire
